/* verilog/ppm_pkg.sv */
package ppm_pkg;

    // Width of one UART byte, which is also one slot value
    localparam int BYTE_W = 8;

    // UART receiver FSM
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

    // Sorter FSM
    // S_SORT runs one compare-swap pass per cycle
    typedef enum logic {
        S_IDLE,
        S_SORT
    } sort_state_t;

    // Modulator FSM
    // M_SLEEP is the only state in which sleep is high
    typedef enum logic {
        M_SLEEP,
        M_SEND
    } mod_state_t;

endpackage

/* verilog/uart_rx.sv */
module uart_rx
    import ppm_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic              clk_carrier,
    input  logic              rst_n,
    input  logic              rx,
    output logic [BYTE_W-1:0] byte_data,
    output logic              byte_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(BYTE_W);

    // Start bit is checked half a bit in, all others one full bit apart
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(BYTE_W - 1);

    rx_state_t         state;
    logic [CNT_W-1:0]  cnt;
    logic [BIT_W-1:0]  bit_idx;
    logic [BYTE_W-1:0] shift;
    logic              sample;

    // Middle of a data bit
    assign sample = (state == DATA) && (cnt == FULL_BIT);

    always_ff @(posedge clk_carrier) begin
        if (!rst_n) begin
            state      <= IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx) begin
                        state <= START;
                    end
                end
                START: begin
                    if (cnt == HALF_BIT) begin
                        cnt <= '0;
                        // Glitch on the line, not a real start bit
                        state <= rx ? IDLE : DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (cnt == FULL_BIT) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            state <= STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (cnt == FULL_BIT) begin
                        state <= IDLE;
                        // Low stop bit means a framing error, byte is dropped
                        byte_valid <= rx;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB first, so new bits enter at the top
    always_ff @(posedge clk_carrier) begin
        if (sample) begin
            shift <= {rx, shift[BYTE_W-1:1]};
        end
    end

    assign byte_data = shift;

endmodule

/* verilog/payload_collector.sv */
module payload_collector
    import ppm_pkg::*;
#(
    parameter int PAYLOAD_BYTES = 4
) (
    input  logic                            clk_carrier,
    input  logic                            rst_n,
    input  logic [BYTE_W-1:0]               byte_data,
    input  logic                            byte_valid,
    output logic [PAYLOAD_BYTES*BYTE_W-1:0] payload,
    output logic                            payload_valid
);

    localparam int PW    = PAYLOAD_BYTES * BYTE_W;
    localparam int CNT_W = $clog2(PAYLOAD_BYTES + 1);

    localparam logic [CNT_W-1:0] LAST = CNT_W'(PAYLOAD_BYTES - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk_carrier) begin
        if (!rst_n) begin
            count         <= '0;
            payload_valid <= 1'b0;
        end else begin
            payload_valid <= 1'b0;
            if (byte_valid) begin
                if (count == LAST) begin
                    // Payload complete, start the next one
                    count         <= '0;
                    payload_valid <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // Shift right so the first byte ends up in the lowest position
    always_ff @(posedge clk_carrier) begin
        if (byte_valid) begin
            payload <= {byte_data, payload[PW-1:BYTE_W]};
        end
    end

endmodule

/* verilog/pulse_sorter.sv */
module pulse_sorter
    import ppm_pkg::*;
#(
    parameter int PAYLOAD_BYTES = 4
) (
    input  logic                            clk_carrier,
    input  logic                            rst_n,
    input  logic [PAYLOAD_BYTES*BYTE_W-1:0] payload,
    input  logic                            payload_valid,
    input  logic                            sleep,
    output logic [PAYLOAD_BYTES*BYTE_W-1:0] sorted,
    output logic                            sorted_valid
);

    localparam int CNT_W = $clog2(PAYLOAD_BYTES + 1);

    // N passes are enough for N values
    localparam logic [CNT_W-1:0] LAST_PASS = CNT_W'(PAYLOAD_BYTES - 1);

    sort_state_t state;
    logic [CNT_W-1:0] pass;
    logic [PAYLOAD_BYTES-1:0][BYTE_W-1:0] arr;
    logic [PAYLOAD_BYTES-1:0][BYTE_W-1:0] arr_next;
    logic accept;

    // Busy sorter or running frame drops the payload
    assign accept = payload_valid && (state == S_IDLE) && sleep;

    // One transposition pass, even pairs on even passes, odd pairs on odd
    always_comb begin
        arr_next = arr;
        for (int i = 0; i + 1 < PAYLOAD_BYTES; i++) begin
            if ((i % 2) == int'(pass[0]) && arr[i] > arr[i+1]) begin
                arr_next[i]   = arr[i+1];
                arr_next[i+1] = arr[i];
            end
        end
    end

    always_ff @(posedge clk_carrier) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            pass         <= '0;
            sorted_valid <= 1'b0;
        end else begin
            sorted_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_SORT;
                        pass  <= '0;
                    end
                end
                S_SORT: begin
                    if (pass == LAST_PASS) begin
                        state        <= S_IDLE;
                        sorted_valid <= 1'b1;
                    end else begin
                        pass <= pass + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_carrier) begin
        if (accept) begin
            arr <= payload;
        end else if (state == S_SORT) begin
            arr <= arr_next;
        end
    end

    // Smallest value sits in the lowest byte
    assign sorted = arr;

endmodule

/* verilog/ppm_modulator.sv */
module ppm_modulator
    import ppm_pkg::*;
#(
    parameter int PAYLOAD_BYTES = 4,
    parameter int SLOT_CYCLES   = 2
) (
    input  logic                            clk_carrier,
    input  logic                            rst_n,
    input  logic [PAYLOAD_BYTES*BYTE_W-1:0] sorted,
    input  logic                            sorted_valid,
    output logic                            wave,
    output logic                            sleep
);

    localparam int PTR_W = $clog2(PAYLOAD_BYTES + 1);
    localparam int IDX_W = $clog2(PAYLOAD_BYTES);
    localparam int CYC_W = (SLOT_CYCLES > 1) ? $clog2(SLOT_CYCLES) : 1;

    localparam logic [CYC_W-1:0]  CYC_LAST  = CYC_W'(SLOT_CYCLES - 1);
    localparam logic [PTR_W-1:0]  PTR_END   = PTR_W'(PAYLOAD_BYTES);
    localparam logic [BYTE_W-1:0] SLOT_LAST = '1;

    mod_state_t state;
    logic [PAYLOAD_BYTES-1:0][BYTE_W-1:0] sorted_arr;
    logic [PAYLOAD_BYTES-1:0][BYTE_W-1:0] vals;
    logic [PAYLOAD_BYTES-1:0][PTR_W-1:0]  nxt_d;
    logic [PAYLOAD_BYTES-1:0][PTR_W-1:0]  nxt;
    logic [PTR_W-1:0]  ptr;
    logic [BYTE_W-1:0] slot;
    logic [CYC_W-1:0]  cyc;
    logic              pending;
    logic              hit;
    logic              slot_end;
    logic              start;

    assign sorted_arr = sorted;

    // Index of the next different value, so duplicates cost one jump
    always_comb begin
        for (int i = 0; i < PAYLOAD_BYTES; i++) begin
            nxt_d[i] = PTR_END;
            for (int j = PAYLOAD_BYTES - 1; j > i; j--) begin
                if (sorted_arr[j] != sorted_arr[i]) begin
                    nxt_d[i] = PTR_W'(j);
                end
            end
        end
    end

    assign start    = (state == M_SLEEP) && sorted_valid;
    assign pending  = (ptr != PTR_END);
    // List is ascending, so only the value under the pointer can match
    assign hit      = pending && (vals[ptr[IDX_W-1:0]] == slot);
    assign slot_end = (cyc == CYC_LAST);

    assign sleep = (state == M_SLEEP);
    assign wave  = (state == M_SEND) && hit;

    always_ff @(posedge clk_carrier) begin
        if (!rst_n) begin
            state <= M_SLEEP;
            slot  <= '0;
            cyc   <= '0;
            ptr   <= '0;
        end else begin
            case (state)
                M_SLEEP: begin
                    if (sorted_valid) begin
                        state <= M_SEND;
                        slot  <= '0;
                        cyc   <= '0;
                        ptr   <= '0;
                    end
                end
                M_SEND: begin
                    if (slot_end) begin
                        cyc  <= '0;
                        slot <= slot + 1'b1;
                        if (hit) begin
                            ptr <= nxt[ptr[IDX_W-1:0]];
                        end
                        // Frame over after slot 255
                        if (slot == SLOT_LAST) begin
                            state <= M_SLEEP;
                        end
                    end else begin
                        cyc <= cyc + 1'b1;
                    end
                end
                default: state <= M_SLEEP;
            endcase
        end
    end

    always_ff @(posedge clk_carrier) begin
        if (start) begin
            vals <= sorted;
            nxt  <= nxt_d;
        end
    end

endmodule

/* verilog/transmitter.sv */
module transmitter
    import ppm_pkg::*;
#(
    parameter int CLKS_PER_BIT  = 16,
    parameter int PAYLOAD_BYTES = 4,
    parameter int SLOT_CYCLES   = 2
) (
    input  logic clk_carrier,
    input  logic rst_n,
    input  logic uart_rxd,
    output logic wave,
    output logic sleep
);

    logic [BYTE_W-1:0]               byte_data;
    logic                            byte_valid;
    logic [PAYLOAD_BYTES*BYTE_W-1:0] payload;
    logic                            payload_valid;
    logic [PAYLOAD_BYTES*BYTE_W-1:0] sorted;
    logic                            sorted_valid;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .clk_carrier(clk_carrier),
        .rst_n      (rst_n),
        .rx         (uart_rxd),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    payload_collector #(
        .PAYLOAD_BYTES(PAYLOAD_BYTES)
    ) u_collector (
        .clk_carrier  (clk_carrier),
        .rst_n        (rst_n),
        .byte_data    (byte_data),
        .byte_valid   (byte_valid),
        .payload      (payload),
        .payload_valid(payload_valid)
    );

    // Sleep feeds back so a payload during a frame is dropped
    pulse_sorter #(
        .PAYLOAD_BYTES(PAYLOAD_BYTES)
    ) u_sorter (
        .clk_carrier  (clk_carrier),
        .rst_n        (rst_n),
        .payload      (payload),
        .payload_valid(payload_valid),
        .sleep        (sleep),
        .sorted       (sorted),
        .sorted_valid (sorted_valid)
    );

    ppm_modulator #(
        .PAYLOAD_BYTES(PAYLOAD_BYTES),
        .SLOT_CYCLES  (SLOT_CYCLES)
    ) u_modulator (
        .clk_carrier (clk_carrier),
        .rst_n       (rst_n),
        .sorted      (sorted),
        .sorted_valid(sorted_valid),
        .wave        (wave),
        .sleep       (sleep)
    );

endmodule

/* verif/transmitter_checker.sv */
module transmitter_checker
    import ppm_pkg::*;
#(
    parameter int PAYLOAD_BYTES = 4
) (
    input logic        clk_carrier,
    input logic        rst_n,
    input logic        sleep,
    input logic        sorted_valid,
    input sort_state_t sort_state,
    input logic        accept
);

    // A sorted result only reaches a sleeping modulator
    result_while_asleep: assert property (@(posedge clk_carrier) disable iff (!rst_n)
        sorted_valid |-> sleep)
        else $error("sorted_valid while a frame runs");

    // Every result traces back to one accepted payload
    idle_no_result: assert property (@(posedge clk_carrier) disable iff (!rst_n)
        sorted_valid |-> (sort_state == S_IDLE) && $past(accept, PAYLOAD_BYTES + 1))
        else $error("sorted_valid without an accepted payload");

    // One load cycle plus one pass per value
    sort_latency: assert property (@(posedge clk_carrier) disable iff (!rst_n)
        accept |-> ##(PAYLOAD_BYTES + 1) sorted_valid)
        else $error("sorted_valid latency wrong");

endmodule

bind transmitter transmitter_checker #(
    .PAYLOAD_BYTES(PAYLOAD_BYTES)
) u_checker (
    .clk_carrier (clk_carrier),
    .rst_n       (rst_n),
    .sleep       (sleep),
    .sorted_valid(sorted_valid),
    .sort_state  (u_sorter.state),
    .accept      (u_sorter.accept)
);

/* verif/tb_transmitter.sv */
module tb_transmitter;

    // UART bit time is shortened so a full payload fits inside one frame
    localparam int CLKS_PER_BIT  = 8;
    localparam int PAYLOAD_BYTES = 4;
    localparam int SLOT_CYCLES   = 2;
    localparam int FRAME_CYCLES  = 256 * SLOT_CYCLES;
    localparam int BYTE_CYCLES   = 11 * CLKS_PER_BIT;
    // Eight frames with their payloads plus half again as margin
    localparam int TEST_CYCLES   = 8 * (2 * PAYLOAD_BYTES * BYTE_CYCLES + FRAME_CYCLES);
    localparam int CYCLE_LIMIT   = TEST_CYCLES * 3 / 2;

    logic clk_carrier;
    logic rst_n;
    logic uart_rxd;
    logic wave;
    logic sleep;

    int           errors;
    int           cycles;
    int           low_cnt;
    int           frames_done;
    int           last_len;
    logic [255:0] cur_mask;
    logic [255:0] last_mask;
    logic [31:0]  lfsr;

    transmitter #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PAYLOAD_BYTES(PAYLOAD_BYTES),
        .SLOT_CYCLES  (SLOT_CYCLES)
    ) dut0 (
        .clk_carrier(clk_carrier),
        .rst_n      (rst_n),
        .uart_rxd   (uart_rxd),
        .wave       (wave),
        .sleep      (sleep)
    );

    initial begin
        clk_carrier = 1'b0;
        forever #2 clk_carrier = ~clk_carrier;
    end

    always @(posedge clk_carrier) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Builds the slot mask of each frame from mid-slot samples of wave
    always @(negedge clk_carrier) begin
        if (rst_n && !sleep) begin
            if (low_cnt % SLOT_CYCLES == SLOT_CYCLES / 2) begin
                cur_mask[low_cnt / SLOT_CYCLES] = wave;
            end
            low_cnt = low_cnt + 1;
        end else if (low_cnt > 0) begin
            last_mask   = cur_mask;
            last_len    = low_cnt;
            cur_mask    = '0;
            low_cnt     = 0;
            frames_done = frames_done + 1;
        end
    end

    task automatic check(input logic [255:0] actual, input logic [255:0] expected,
                         input string msg);
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s (got %0h, expected %0h)", $time, msg, actual,
                     expected);
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    function automatic logic [255:0] slot_set(input logic [31:0] bytes);
        logic [255:0] m;
        m = '0;
        for (int i = 0; i < PAYLOAD_BYTES; i++) begin
            m[bytes[8*i+:8]] = 1'b1;
        end
        return m;
    endfunction

    // Start, eight data bits LSB first, stop, then one idle bit
    task automatic uart_send(input logic [7:0] b, input logic bad_stop);
        logic [10:0] frame;
        frame = {1'b1, ~bad_stop, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            uart_rxd = frame[i];
            repeat (CLKS_PER_BIT) @(negedge clk_carrier);
        end
    endtask

    task automatic send_payload(input logic [31:0] bytes);
        for (int i = 0; i < PAYLOAD_BYTES; i++) begin
            uart_send(bytes[8*i+:8], 1'b0);
        end
    endtask

    task automatic frame_test(input logic [31:0] bytes, input string name);
        int n;
        n = frames_done;
        send_payload(bytes);
        wait (frames_done == n + 1);
        check(last_mask, slot_set(bytes), {name, " slot mask"});
        check(256'(last_len), 256'(FRAME_CYCLES), {name, " frame length"});
    endtask

    task automatic reset_test();
        repeat (20) begin
            @(negedge clk_carrier);
            check(256'(sleep), 256'(1), "sleep after reset");
            check(256'(wave), 256'(0), "wave after reset");
        end
    endtask

    task automatic framing_error_test();
        int n;
        n = frames_done;
        uart_send(8'd40, 1'b0);
        uart_send(8'd99, 1'b1);
        uart_send(8'd41, 1'b0);
        uart_send(8'd42, 1'b0);
        check(256'(sleep), 256'(1), "sleep before fourth good byte");
        uart_send(8'd43, 1'b0);
        wait (frames_done == n + 1);
        check(last_mask, slot_set(32'h2b2a2928), "framing error slot mask");
    endtask

    task automatic busy_drop_test();
        int n;
        n = frames_done;
        send_payload(32'h10f00564);
        check(256'(sleep), 256'(0), "frame running before second payload");
        send_payload(32'h0a0b0c0d);
        wait (frames_done == n + 1);
        check(last_mask, slot_set(32'h10f00564), "mask with dropped payload");
        repeat (40) @(negedge clk_carrier);
        check(256'(sleep), 256'(1), "sleep after dropped payload");
    endtask

    task automatic random_test();
        logic [31:0] bytes;
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < PAYLOAD_BYTES; i++) begin
                bytes[8*i+:8] = rand_byte();
            end
            frame_test(bytes, "random payload");
        end
    endtask

    initial begin
        errors      = 0;
        cycles      = 0;
        low_cnt     = 0;
        frames_done = 0;
        last_len    = 0;
        cur_mask    = '0;
        last_mask   = '0;
        lfsr        = 32'h50539f2b;
        rst_n       = 1'b0;
        uart_rxd    = 1'b1;
        repeat (10) @(negedge clk_carrier);
        rst_n = 1'b1;

        reset_test();
        frame_test({8'd15, 8'd77, 8'd3, 8'd200}, "distinct values");
        frame_test({8'd9, 8'd120, 8'd9, 8'd9}, "duplicate values");
        framing_error_test();
        busy_drop_test();
        random_test();

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/ppm_pkg.sv
verilog/uart_rx.sv
verilog/payload_collector.sv
verilog/pulse_sorter.sv
verilog/ppm_modulator.sv
verilog/transmitter.sv
verif/transmitter_checker.sv
verif/tb_transmitter.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the transmitter testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_transmitter \
    -f filelist.f \
    -o sim_transmitter

# An assertion stop ends the binary with an error status
./obj_dir/sim_transmitter > sim.log 2>&1 || echo "Result: FAILED" >> sim.log
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
